//--- rtl/u2_io_macros.svh
`ifndef U2_IO_MACROS_SVH
`define U2_IO_MACROS_SVH

// Converter sample width, without the overflow flag
`define U2_ADC_WIDTH 14

// DAC sample width per channel
`define U2_DAC_WIDTH 16

// Capture register depth between ADC pins and logical channels.
// This is also the ADC path latency in dsp_clk cycles.
`define U2_ADC_STAGES 2

// Kick counter width, the top bit drives the supervisor input
`define U2_WD_WIDTH 16

// Number of active-low SPI chip-selects
`define U2_SPI_TARGETS 8

`endif

//--- rtl/board_io_pkg.sv
`default_nettype none

`include "u2_io_macros.svh"

package board_io_pkg;

   // One converter channel as it arrives at the pins
   typedef struct packed
   {
      logic                     ovf;    // Converter overflow flag
      logic [`U2_ADC_WIDTH-1:0] data;
   } adc_sample_t;

   // Both channels after the swap, logical naming
   typedef struct packed
   {
      adc_sample_t a;
      adc_sample_t b;
   } adc_pair_t;

   // Enables as the core drives them, active high
   typedef struct packed
   {
      logic on_a;
      logic oe_a;
      logic on_b;
      logic oe_b;
   } adc_ctrl_t;

   // Same enables at the converter pins, active low
   typedef struct packed
   {
      logic pdn_a;    // Power-down
      logic oen_a;    // Output enable
      logic pdn_b;
      logic oen_b;
   } adc_pins_t;

   // Outgoing DAC samples, logical naming
   typedef struct packed
   {
      logic [`U2_DAC_WIDTH-1:0] a;
      logic [`U2_DAC_WIDTH-1:0] b;
   } dac_pair_t;

endpackage : board_io_pkg

`default_nettype wire

//--- rtl/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

   // Chip-selects from the SPI master, all active low
   typedef struct packed
   {
      logic sen_clk;       // Clock generator
      logic sen_dac;       // Main DAC
      logic sen_tx_db;
      logic sen_tx_adc;
      logic sen_tx_dac;
      logic sen_rx_db;
      logic sen_rx_adc;
      logic sen_rx_dac;
   } spi_sel_t;

   // Return lines from the targets that have one.
   // The daughterboard DACs are write only.
   typedef struct packed
   {
      logic sdo;           // Shared by clock generator and main DAC
      logic sdo_tx_db;
      logic sdo_tx_adc;
      logic sdo_rx_db;
      logic sdo_rx_adc;
   } spi_sdo_t;

   // Clock and data toward one target group
   typedef struct packed
   {
      logic sclk;
      logic sdi;
   } spi_pair_t;

   // Routed clock/data pins, one pair per group
   typedef struct packed
   {
      spi_pair_t main;     // Clock generator and main DAC together
      spi_pair_t tx_db;
      spi_pair_t tx_adc;
      spi_pair_t tx_dac;
      spi_pair_t rx_db;
      spi_pair_t rx_adc;
      spi_pair_t rx_dac;
   } spi_pins_t;

endpackage : spi_bus_pkg

`default_nettype wire

//--- rtl/adc_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module adc_capture
   import board_io_pkg::*;
(
   input  wire         dsp_clk,
   input  wire         reset_i,
   input  adc_sample_t adc_raw_a_i,   // Physical A pins
   input  adc_sample_t adc_raw_b_i,   // Physical B pins
   input  adc_ctrl_t   adc_ctrl_i,
   output adc_pair_t   adc_o,
   output adc_pins_t   adc_pins_o
);

   adc_pair_t swapped;
   adc_pair_t stage_q [`U2_ADC_STAGES];

   // Converters A and B are crossed on the board, so physical B
   // is logical a and the reverse. Overflow flags go along.
   assign swapped.a = adc_raw_b_i;
   assign swapped.b = adc_raw_a_i;

   // Capture pipeline, first stage right at the pins
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         for (int i = 0; i < `U2_ADC_STAGES; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= swapped;
         for (int i = 1; i < `U2_ADC_STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];   // Retime for converter skew
         end
      end
   end

   assign adc_o = stage_q[`U2_ADC_STAGES-1];

   // Enable pins on the converters are active low
   assign adc_pins_o.pdn_a = ~adc_ctrl_i.on_a;
   assign adc_pins_o.oen_a = ~adc_ctrl_i.oe_a;
   assign adc_pins_o.pdn_b = ~adc_ctrl_i.on_b;
   assign adc_pins_o.oen_b = ~adc_ctrl_i.oe_b;

endmodule : adc_capture

`default_nettype wire

//--- rtl/dac_drive.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module dac_drive
   import board_io_pkg::*;
(
   input  wire                            dsp_clk,
   input  wire                            reset_i,
   input  dac_pair_t                      dac_i,
   output logic [`U2_DAC_WIDTH-1:0]       dac_a_o,   // Physical A pins
   output logic [`U2_DAC_WIDTH-1:0]       dac_b_o    // Physical B pins
);

   // The board crosses the two DAC channels and inverts the
   // A side in the layout. Undo both here so the analog
   // outputs match the logical channel naming.
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
      else
      begin
         dac_a_o <= ~dac_i.b;   // Swapped and inverted
         dac_b_o <= dac_i.a;    // Swapped only
      end
   end

endmodule : dac_drive

`default_nettype wire

//--- rtl/spi_fanout.sv
`timescale 1ns/10ps
`default_nettype none

module spi_fanout
   import spi_bus_pkg::*;
(
   input  wire       sclk_i,
   input  wire       mosi_i,
   input  spi_sel_t  sel_i,      // Active low
   input  spi_sdo_t  sdo_i,
   output spi_pins_t pins_o,
   output logic      miso_o
);

   spi_pair_t live;      // What a selected group sees
   logic      main_en;

   assign live.sclk = sclk_i;
   assign live.sdi  = mosi_i;

   // Clock generator and main DAC share one clock/data pair
   assign main_en = ~sel_i.sen_clk | ~sel_i.sen_dac;

   // Idle groups get a quiet bus, no stray clock edges
   always_comb
   begin
      pins_o = '0;
      if (main_en)
      begin
         pins_o.main = live;
      end
      if (!sel_i.sen_tx_db)
      begin
         pins_o.tx_db = live;
      end
      if (!sel_i.sen_tx_adc)
      begin
         pins_o.tx_adc = live;
      end
      if (!sel_i.sen_tx_dac)
      begin
         pins_o.tx_dac = live;
      end
      if (!sel_i.sen_rx_db)
      begin
         pins_o.rx_db = live;
      end
      if (!sel_i.sen_rx_adc)
      begin
         pins_o.rx_adc = live;
      end
      if (!sel_i.sen_rx_dac)
      begin
         pins_o.rx_dac = live;
      end
   end

   // Only selected targets may drive the return path.
   // Shared sdo is taken once per select that owns it.
   assign miso_o = (~sel_i.sen_clk    & sdo_i.sdo)        |
                   (~sel_i.sen_dac    & sdo_i.sdo)        |
                   (~sel_i.sen_tx_db  & sdo_i.sdo_tx_db)  |
                   (~sel_i.sen_tx_adc & sdo_i.sdo_tx_adc) |
                   (~sel_i.sen_rx_db  & sdo_i.sdo_rx_db)  |
                   (~sel_i.sen_rx_adc & sdo_i.sdo_rx_adc);

endmodule : spi_fanout

`default_nettype wire

//--- rtl/watchdog_kick.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module watchdog_kick #(
   parameter int KICK_BITS = `U2_WD_WIDTH   // 2 or more
)
(
   input  wire  dsp_clk,
   input  wire  reset_i,
   input  wire  config_success_i,
   output logic wdi_o
);

   logic [KICK_BITS-1:0] kick_cnt;

   // External supervisor resets the board unless WDI keeps moving.
   // Hold it still until configuration is known good, so a bad
   // image gets reloaded.
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i || !config_success_i)
      begin
         kick_cnt <= '0;
      end
      else
      begin
         kick_cnt <= kick_cnt + 1'b1;   // Free running, wraps
      end
   end

   // Top bit gives a square wave of 2**(KICK_BITS-1) half period
   assign wdi_o = kick_cnt[KICK_BITS-1];

endmodule : watchdog_kick

`default_nettype wire

//--- rtl/u2_board_io.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module u2_board_io
   import board_io_pkg::*;
   import spi_bus_pkg::*;
(
   input  wire                       dsp_clk,
   input  wire                       reset_i,

   // ADC
   input  adc_sample_t               adc_raw_a_i,
   input  adc_sample_t               adc_raw_b_i,
   input  adc_ctrl_t                 adc_ctrl_i,
   output adc_pair_t                 adc_o,
   output adc_pins_t                 adc_pins_o,

   // DAC
   input  dac_pair_t                 dac_i,
   output logic [`U2_DAC_WIDTH-1:0]  dac_a_o,
   output logic [`U2_DAC_WIDTH-1:0]  dac_b_o,

   // SPI master side and target side
   input  wire                       sclk_i,
   input  wire                       mosi_i,
   input  spi_sel_t                  sel_i,
   input  spi_sdo_t                  sdo_i,
   output spi_pins_t                 pins_o,
   output logic                      miso_o,

   // Supervisor
   input  wire                       config_success_i,
   output logic                      wdi_o
);

   // Converter capture, two cycles from pins to adc_o
   adc_capture adc_capture_i (
      .dsp_clk     (dsp_clk),
      .reset_i     (reset_i),
      .adc_raw_a_i (adc_raw_a_i),
      .adc_raw_b_i (adc_raw_b_i),
      .adc_ctrl_i  (adc_ctrl_i),
      .adc_o       (adc_o),
      .adc_pins_o  (adc_pins_o)
   );

   dac_drive dac_drive_i (
      .dsp_clk (dsp_clk),
      .reset_i (reset_i),
      .dac_i   (dac_i),
      .dac_a_o (dac_a_o),
      .dac_b_o (dac_b_o)
   );

   // No clock here, pure routing
   spi_fanout spi_fanout_i (
      .sclk_i (sclk_i),
      .mosi_i (mosi_i),
      .sel_i  (sel_i),
      .sdo_i  (sdo_i),
      .pins_o (pins_o),
      .miso_o (miso_o)
   );

   watchdog_kick #(
      .KICK_BITS (`U2_WD_WIDTH)
   ) watchdog_kick_i (
      .dsp_clk          (dsp_clk),
      .reset_i          (reset_i),
      .config_success_i (config_success_i),
      .wdi_o            (wdi_o)
   );

endmodule : u2_board_io

`default_nettype wire

//--- sim/u2_board_io_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module u2_board_io_props
   import board_io_pkg::*;
   import spi_bus_pkg::*;
(
   input wire                       dsp_clk,
   input wire                       reset_i,
   input adc_sample_t               adc_raw_a_i,
   input adc_sample_t               adc_raw_b_i,
   input adc_pair_t                 adc_o,
   input dac_pair_t                 dac_i,
   input logic [`U2_DAC_WIDTH-1:0]  dac_a_o,
   input logic [`U2_DAC_WIDTH-1:0]  dac_b_o,
   input spi_sel_t                  sel_i,
   input spi_pins_t                 pins_o,
   input wire                       config_success_i,
   input wire                       wdi_o
);

   logic [6:0] grp_idle;   // Main group first
   logic [6:0] grp_busy;

   assign grp_idle = {sel_i.sen_clk & sel_i.sen_dac, sel_i.sen_tx_db, sel_i.sen_tx_adc,
                      sel_i.sen_tx_dac, sel_i.sen_rx_db, sel_i.sen_rx_adc, sel_i.sen_rx_dac};
   assign grp_busy = {|pins_o.main, |pins_o.tx_db, |pins_o.tx_adc, |pins_o.tx_dac,
                      |pins_o.rx_db, |pins_o.rx_adc, |pins_o.rx_dac};

   // Physical B lands on logical a two edges later
   adc_latency: assert property (@(posedge dsp_clk) disable iff (reset_i)
      !$past(reset_i) && !$past(reset_i, 2) |-> adc_o == $past({adc_raw_b_i, adc_raw_a_i}, 2))
      else $error("ADC capture latency or channel swap broken");

   dac_latency: assert property (@(posedge dsp_clk) disable iff (reset_i)
      !$past(reset_i) |-> dac_a_o == ~$past(dac_i.b) && dac_b_o == $past(dac_i.a))
      else $error("DAC output does not follow its input after one edge");

   spi_idle_quiet: assert property (@(posedge dsp_clk) (grp_idle & grp_busy) == '0)
      else $error("Unselected SPI pair is not held at zero");

   wdi_held_low: assert property (@(posedge dsp_clk) !config_success_i |=> !wdi_o)
      else $error("Watchdog kick moved without configuration success");

endmodule : u2_board_io_props

bind u2_board_io u2_board_io_props props_i (.*);

`default_nettype wire

//--- sim/tb_u2_board_io.sv
`timescale 1ns/10ps
`default_nettype none

`include "u2_io_macros.svh"

module tb_u2_board_io
   import board_io_pkg::*;
   import spi_bus_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 2;
   localparam int RESET_CYCLES = 5;
   localparam int HALF_KICK    = 1 << (`U2_WD_WIDTH - 1);
   // Kick test dominates and the short tests fit in the extra cycles
   localparam int     EST_CYCLES = 2 * HALF_KICK + 2000;
   localparam longint TIMEOUT_NS = 2 * longint'(EST_CYCLES) * CLK_PERIOD;

   logic                     dsp_clk;
   logic                     reset_i;
   adc_sample_t              adc_raw_a_i;
   adc_sample_t              adc_raw_b_i;
   adc_ctrl_t                adc_ctrl_i;
   adc_pair_t                adc_o;
   adc_pins_t                adc_pins_o;
   dac_pair_t                dac_i;
   logic [`U2_DAC_WIDTH-1:0] dac_a_o;
   logic [`U2_DAC_WIDTH-1:0] dac_b_o;
   logic                     sclk_i;
   logic                     mosi_i;
   spi_sel_t                 sel_i;
   spi_sdo_t                 sdo_i;
   spi_pins_t                pins_o;
   logic                     miso_o;
   logic                     config_success_i;
   logic                     wdi_o;

   u2_board_io uut (.*);

   initial dsp_clk = 1'b0;
   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         abort_run($sformatf("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic next_slot();
      @(posedge dsp_clk);
      #DRIVE_DELAY;   // Drive point after the edge
   endtask

   // Pair order main, tx_db, tx_adc, tx_dac, rx_db, rx_adc, rx_dac from the top
   function automatic logic [13:0] expected_pins(input logic [7:0] sel, input logic sclk,
                                                 input logic mosi);
      logic [6:0]  live;
      logic [13:0] pins;
      live = {~sel[7] | ~sel[6], ~sel[5:0]};
      for (int k = 0; k < 7; k++)
      begin
         pins[2*k +: 2] = live[k] ? {sclk, mosi} : 2'b00;
      end
      return pins;
   endfunction

   function automatic logic expected_miso(input spi_sel_t sel, input spi_sdo_t sdo);
      logic [4:0] driving;   // Return lines whose owner is selected
      driving = {(~sel.sen_clk | ~sel.sen_dac) & sdo.sdo,
                 ~sel.sen_tx_db & sdo.sdo_tx_db,
                 ~sel.sen_tx_adc & sdo.sdo_tx_adc,
                 ~sel.sen_rx_db & sdo.sdo_rx_db,
                 ~sel.sen_rx_adc & sdo.sdo_rx_adc};
      return |driving;
   endfunction

   task automatic test_reset_values();
      check_eq("adc_o.a", 32'd0, 32'(adc_o.a));
      check_eq("adc_o.b", 32'd0, 32'(adc_o.b));
      check_eq("dac_a_o", 32'd0, 32'(dac_a_o));
      check_eq("dac_b_o", 32'd0, 32'(dac_b_o));
      check_eq("wdi_o", 32'd0, 32'(wdi_o));
   endtask

   task automatic test_adc_capture();
      adc_sample_t sent_a [20];
      adc_sample_t sent_b [20];
      adc_ctrl_t   ctrl;
      logic [31:0] r;
      for (int i = 0; i < 22; i++)
      begin
         if (i >= 2)
         begin
            check_eq("adc_o.a", 32'(sent_b[i-2]), 32'(adc_o.a));   // Crossed channels
            check_eq("adc_o.b", 32'(sent_a[i-2]), 32'(adc_o.b));
         end
         if (i < 20)
         begin
            r = $urandom();
            sent_a[i] = r[`U2_ADC_WIDTH:0];
            r = $urandom();
            sent_b[i] = r[`U2_ADC_WIDTH:0];
            r = $urandom();
            ctrl = r[3:0];
            adc_raw_a_i = sent_a[i];
            adc_raw_b_i = sent_b[i];
            adc_ctrl_i  = ctrl;
            #1;
            check_eq("adc_pins_o",
                     32'({~ctrl.on_a, ~ctrl.oe_a, ~ctrl.on_b, ~ctrl.oe_b}), 32'(adc_pins_o));
         end
         next_slot();
      end
   endtask

   task automatic test_dac_drive();
      dac_pair_t                pair;
      logic [`U2_DAC_WIDTH-1:0] exp_a;
      logic [31:0]              r;
      for (int i = 0; i < 16; i++)
      begin
         r = $urandom();
         pair  = r;
         dac_i = pair;
         exp_a = ~pair.b;
         next_slot();
         check_eq("dac_a_o", 32'(exp_a), 32'(dac_a_o));
         check_eq("dac_b_o", 32'(pair.a), 32'(dac_b_o));
      end
   endtask

   task automatic test_spi_routing();
      logic [7:0]  sel_list [`U2_SPI_TARGETS + 2];
      logic [31:0] r;
      for (int s = 0; s < `U2_SPI_TARGETS; s++)
      begin
         sel_list[s] = ~(8'd1 << s);
      end
      sel_list[`U2_SPI_TARGETS]     = 8'b0011_1111;   // Clock generator and main DAC together
      sel_list[`U2_SPI_TARGETS + 1] = 8'hff;
      for (int j = 0; j < `U2_SPI_TARGETS + 2; j++)
      begin
         for (int n = 0; n < 4; n++)
         begin
            r = $urandom();
            sclk_i = r[0];
            mosi_i = r[1];
            sel_i  = sel_list[j];
            #1;
            check_eq("pins_o", 32'(expected_pins(sel_list[j], r[0], r[1])), 32'(pins_o));
            next_slot();
         end
      end
   endtask

   task automatic test_spi_merge();
      spi_sel_t    sel;
      spi_sdo_t    sdo;
      logic [31:0] r;
      for (int i = 0; i < 32; i++)
      begin
         r = $urandom();
         sel = (i == 0) ? 8'hff : r[7:0];
         sdo = r[12:8];
         sel_i = sel;
         sdo_i = sdo;
         #1;
         check_eq("miso_o", 32'(expected_miso(sel, sdo)), 32'(miso_o));
         next_slot();
      end
   endtask

   task automatic test_watchdog_kick();
      int edges;
      config_success_i = 1'b0;
      repeat (100)
      begin
         next_slot();
         check_eq("wdi_o", 32'd0, 32'(wdi_o));
      end
      config_success_i = 1'b1;
      edges = 0;
      while (wdi_o !== 1'b1 && edges < HALF_KICK + 10)
      begin
         next_slot();
         edges++;
      end
      check_eq("wdi_o rise edge count", 32'(HALF_KICK), 32'(edges));
      config_success_i = 1'b0;
      next_slot();
      check_eq("wdi_o", 32'd0, 32'(wdi_o));   // Cleared on the first edge
   endtask

   initial
   begin
      void'($urandom(32'h84d8_9cae));
      reset_i          = 1'b1;
      adc_raw_a_i      = '0;
      adc_raw_b_i      = '0;
      adc_ctrl_i       = '0;
      dac_i            = '0;
      sclk_i           = 1'b0;
      mosi_i           = 1'b0;
      sel_i            = '1;   // Nothing selected
      sdo_i            = '0;
      config_success_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #DRIVE_DELAY;
      reset_i = 1'b0;
      test_reset_values();
      test_adc_capture();
      test_dac_drive();
      test_spi_routing();
      test_spi_merge();
      test_watchdog_kick();
      $display("RESULT: PASS");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      abort_run($sformatf("Timeout, tests did not finish within %0d ns", TIMEOUT_NS));
   end

endmodule : tb_u2_board_io

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/board_io_pkg.sv
rtl/spi_bus_pkg.sv
rtl/adc_capture.sv
rtl/dac_drive.sv
rtl/spi_fanout.sv
rtl/watchdog_kick.sv
rtl/u2_board_io.sv
sim/u2_board_io_props.sv
sim/tb_u2_board_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the board I/O testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert \
   --top-module tb_u2_board_io \
   -f filelist.f \
   -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$LOG"

if grep -qx "RESULT: PASS" "$LOG"
then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
